// ==== include/l2_params.svh ====
`ifndef L2_PARAMS_SVH
`define L2_PARAMS_SVH

// Line address width, one line is the unit of transfer
`define L2_ADDR_W 28

// Bits per cache line
`define L2_LINE_W 128

// Direct mapped, one line per set
`define L2_INDEX_W 5

// Upper part of the line address
`define L2_TAG_W 23

`define L2_SETS 32

`endif

// ==== hw/l2_pkg.sv ====
`include "l2_params.svh"

package l2_pkg;

    typedef logic [`L2_ADDR_W-1:0]  line_addr_t;
    typedef logic [`L2_LINE_W-1:0]  line_data_t;
    typedef logic [`L2_INDEX_W-1:0] set_index_t;
    typedef logic [`L2_TAG_W-1:0]   line_tag_t;

    // Request from an L1 port, held until ready
    typedef struct packed {
        logic       read;
        logic       write;
        line_addr_t addr;
        line_data_t wdata;
    } l2_req_t;

    // Command on the external memory bus
    typedef struct packed {
        logic       read;
        logic       write;
        line_addr_t addr;
        line_data_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic       rd;
        logic       wr;
        set_index_t index;
        line_tag_t  tag;
        logic       dirty;
        line_data_t data;
    } array_req_t;

    // Lookup result, one cycle after rd
    typedef struct packed {
        logic       hit;
        logic       valid;
        logic       dirty;
        line_tag_t  tag;
        line_data_t data;
    } array_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        ALLOCATE,
        FILL,
        RESPOND
    } port_state_e;

endpackage

// ==== hw/l2_port_arbiter.sv ====
`timescale 1ns/1ps

module l2_port_arbiter (
    input  logic       clk,
    input  logic       proc_reset,
    input  logic [1:0] want_i,
    output logic [1:0] grant_o
);

    logic [1:0] grant_q;
    logic [1:0] grant_d;
    // Requester that got the last new grant
    logic       last_q;

    always_comb begin
        grant_d = 2'b00;
        if (grant_q[0] && want_i[0]) begin
            grant_d = 2'b01;
        end else if (grant_q[1] && want_i[1]) begin
            grant_d = 2'b10;
        end else if (want_i == 2'b11) begin
            // Both waiting, favour the one not served last
            grant_d = last_q ? 2'b01 : 2'b10;
        end else begin
            grant_d = want_i;
        end
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            grant_q <= 2'b00;
            last_q  <= 1'b1;
        end else begin
            grant_q <= grant_d;
            if (grant_d != 2'b00) begin
                last_q <= grant_d[1];
            end
        end
    end

    assign grant_o = grant_q;

endmodule

// ==== hw/l2_tag_data_array.sv ====
`timescale 1ns/1ps

`include "l2_params.svh"

module l2_tag_data_array (
    input  logic                   clk,
    input  logic                   proc_reset,
    input  l2_pkg::array_req_t     req_i,
    output l2_pkg::array_rsp_t     rsp_o,
    input  l2_pkg::line_tag_t      lookup_tag_i
);

    logic [`L2_SETS-1:0] valid_q;
    logic [`L2_SETS-1:0] dirty_q;

    l2_pkg::line_tag_t  tag_mem  [`L2_SETS];
    l2_pkg::line_data_t data_mem [`L2_SETS];

    // Registered read port
    logic               rd_valid_q;
    logic               rd_dirty_q;
    l2_pkg::line_tag_t  rd_tag_q;
    l2_pkg::line_data_t rd_data_q;
    l2_pkg::line_tag_t  cmp_tag_q;

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (req_i.wr) begin
            valid_q[req_i.index] <= 1'b1;
            dirty_q[req_i.index] <= req_i.dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (req_i.wr) begin
            tag_mem[req_i.index]  <= req_i.tag;
            data_mem[req_i.index] <= req_i.data;
        end
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            rd_valid_q <= 1'b0;
            rd_dirty_q <= 1'b0;
        end else if (req_i.rd) begin
            rd_valid_q <= valid_q[req_i.index];
            rd_dirty_q <= dirty_q[req_i.index];
        end
    end

    always_ff @(posedge clk) begin
        if (req_i.rd) begin
            rd_tag_q  <= tag_mem[req_i.index];
            rd_data_q <= data_mem[req_i.index];
            cmp_tag_q <= lookup_tag_i;
        end
    end

    always_comb begin
        rsp_o.valid = rd_valid_q;
        rsp_o.dirty = rd_dirty_q;
        rsp_o.tag   = rd_tag_q;
        rsp_o.data  = rd_data_q;
        rsp_o.hit   = rd_valid_q && (rd_tag_q == cmp_tag_q);
    end

endmodule

// ==== hw/l2_port_ctrl.sv ====
`timescale 1ns/1ps

`include "l2_params.svh"

module l2_port_ctrl (
    input  logic                clk,
    input  logic                proc_reset,
    input  l2_pkg::l2_req_t     l1_req_i,
    output l2_pkg::line_data_t  l1_rdata_o,
    output logic                l1_ready_o,
    output logic                want_o,
    input  logic                grant_i,
    output l2_pkg::array_req_t  array_req_o,
    output l2_pkg::line_tag_t   lookup_tag_o,
    input  l2_pkg::array_rsp_t  array_rsp_i,
    output l2_pkg::mem_req_t    mem_req_o,
    input  l2_pkg::line_data_t  mem_rdata_i,
    input  logic                mem_ready_i
);

    l2_pkg::port_state_e state_q;
    l2_pkg::port_state_e state_d;

    // Second cycle of LOOKUP, array response is valid
    logic               looked_q;
    // Blocks want for one cycle after a response
    logic               done_q;
    l2_pkg::line_data_t line_q;
    l2_pkg::line_tag_t  victim_tag_q;

    l2_pkg::set_index_t req_index;
    l2_pkg::line_tag_t  req_tag;
    logic               req_active;
    logic               hit_ready;
    logic               victim_capture;

    assign req_index  = l1_req_i.addr[`L2_INDEX_W-1:0];
    assign req_tag    = l1_req_i.addr[`L2_ADDR_W-1:`L2_INDEX_W];
    assign req_active = l1_req_i.read || l1_req_i.write;

    assign victim_capture = (state_q == l2_pkg::LOOKUP) && looked_q && !array_rsp_i.hit;

    always_comb begin
        state_d   = state_q;
        want_o    = 1'b1;
        hit_ready = 1'b0;

        array_req_o       = '0;
        array_req_o.index = req_index;
        array_req_o.tag   = req_tag;
        array_req_o.data  = l1_req_i.wdata;

        mem_req_o       = '0;
        mem_req_o.addr  = l1_req_i.addr;
        mem_req_o.wdata = line_q;

        case (state_q)
            l2_pkg::IDLE: begin
                want_o = req_active && !done_q;
                if (req_active && !done_q && grant_i) begin
                    state_d = l2_pkg::LOOKUP;
                end
            end

            l2_pkg::LOOKUP: begin
                if (!looked_q) begin
                    array_req_o.rd = 1'b1;
                end else if (array_rsp_i.hit) begin
                    // Hit, a write only needs the dirty update
                    hit_ready         = 1'b1;
                    array_req_o.wr    = l1_req_i.write;
                    array_req_o.dirty = 1'b1;
                    state_d           = l2_pkg::IDLE;
                end else if (array_rsp_i.valid && array_rsp_i.dirty) begin
                    state_d = l2_pkg::WRITEBACK;
                end else begin
                    state_d = l2_pkg::ALLOCATE;
                end
            end

            l2_pkg::WRITEBACK: begin
                mem_req_o.write = 1'b1;
                mem_req_o.addr  = {victim_tag_q, req_index};
                if (mem_ready_i) begin
                    state_d = l2_pkg::ALLOCATE;
                end
            end

            l2_pkg::ALLOCATE: begin
                mem_req_o.read = 1'b1;
                if (mem_ready_i) begin
                    state_d = l2_pkg::FILL;
                end
            end

            l2_pkg::FILL: begin
                array_req_o.wr    = 1'b1;
                array_req_o.dirty = l1_req_i.write;
                array_req_o.data  = line_q;
                state_d           = l2_pkg::RESPOND;
            end

            l2_pkg::RESPOND: begin
                state_d = l2_pkg::IDLE;
            end

            default: begin
                state_d = l2_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state_q  <= l2_pkg::IDLE;
            looked_q <= 1'b0;
            done_q   <= 1'b0;
            line_q   <= '0;
        end else begin
            state_q  <= state_d;
            looked_q <= (state_q == l2_pkg::LOOKUP) && !looked_q;
            done_q   <= l1_ready_o;
            if (victim_capture) begin
                line_q <= array_rsp_i.data;
            end else if ((state_q == l2_pkg::ALLOCATE) && mem_ready_i) begin
                // Write miss fills with the L1 line instead
                line_q <= l1_req_i.write ? l1_req_i.wdata : mem_rdata_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (victim_capture) begin
            victim_tag_q <= array_rsp_i.tag;
        end
    end

    assign lookup_tag_o = req_tag;
    assign l1_ready_o   = hit_ready || (state_q == l2_pkg::RESPOND);
    assign l1_rdata_o   = hit_ready ? array_rsp_i.data : line_q;

endmodule

// ==== hw/l2_cache_top.sv ====
`timescale 1ns/1ps

module l2_cache_top (
    input  logic               clk,
    input  logic               proc_reset,
    input  l2_pkg::l2_req_t    l1i_req_i,
    output l2_pkg::line_data_t l1i_rdata_o,
    output logic               l1i_ready_o,
    input  l2_pkg::l2_req_t    l1d_req_i,
    output l2_pkg::line_data_t l1d_rdata_o,
    output logic               l1d_ready_o,
    output l2_pkg::mem_req_t   mem_req_o,
    input  l2_pkg::line_data_t mem_rdata_i,
    input  logic               mem_ready_i
);

    // Bit 0 is the instruction side, bit 1 the data side
    logic [1:0] want;
    logic [1:0] grant;

    l2_pkg::array_req_t i_array_req;
    l2_pkg::array_req_t d_array_req;
    l2_pkg::array_req_t array_req;
    l2_pkg::array_rsp_t array_rsp;
    l2_pkg::line_tag_t  i_lookup_tag;
    l2_pkg::line_tag_t  d_lookup_tag;
    l2_pkg::line_tag_t  lookup_tag;
    l2_pkg::mem_req_t   i_mem_req;
    l2_pkg::mem_req_t   d_mem_req;
    l2_pkg::line_data_t i_mem_rdata;
    l2_pkg::line_data_t d_mem_rdata;

    assign i_mem_rdata = grant[0] ? mem_rdata_i : '0;
    assign d_mem_rdata = grant[1] ? mem_rdata_i : '0;

    always_comb begin
        array_req  = '0;
        lookup_tag = '0;
        mem_req_o  = '0;
        if (grant[0]) begin
            array_req  = i_array_req;
            lookup_tag = i_lookup_tag;
            mem_req_o  = i_mem_req;
        end else if (grant[1]) begin
            array_req  = d_array_req;
            lookup_tag = d_lookup_tag;
            mem_req_o  = d_mem_req;
        end
    end

    l2_port_ctrl i_l2_port_ctrl_l1i (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .l1_req_i     (l1i_req_i),
        .l1_rdata_o   (l1i_rdata_o),
        .l1_ready_o   (l1i_ready_o),
        .want_o       (want[0]),
        .grant_i      (grant[0]),
        .array_req_o  (i_array_req),
        .lookup_tag_o (i_lookup_tag),
        .array_rsp_i  (array_rsp),
        .mem_req_o    (i_mem_req),
        .mem_rdata_i  (i_mem_rdata),
        .mem_ready_i  (mem_ready_i && grant[0])
    );

    l2_port_ctrl i_l2_port_ctrl_l1d (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .l1_req_i     (l1d_req_i),
        .l1_rdata_o   (l1d_rdata_o),
        .l1_ready_o   (l1d_ready_o),
        .want_o       (want[1]),
        .grant_i      (grant[1]),
        .array_req_o  (d_array_req),
        .lookup_tag_o (d_lookup_tag),
        .array_rsp_i  (array_rsp),
        .mem_req_o    (d_mem_req),
        .mem_rdata_i  (d_mem_rdata),
        .mem_ready_i  (mem_ready_i && grant[1])
    );

    l2_port_arbiter i_l2_port_arbiter (
        .clk        (clk),
        .proc_reset (proc_reset),
        .want_i     (want),
        .grant_o    (grant)
    );

    l2_tag_data_array i_l2_tag_data_array (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .req_i        (array_req),
        .rsp_o        (array_rsp),
        .lookup_tag_i (lookup_tag)
    );

endmodule

// ==== verification/l2_mem_model.sv ====
`timescale 1ns/1ps

module l2_mem_model #(
    parameter l2_pkg::line_data_t FILL_XOR = '0,
    parameter int unsigned        SEED     = 0
) (
    input  logic               clk,
    input  logic               proc_reset,
    input  l2_pkg::mem_req_t   mem_req_i,
    output l2_pkg::line_data_t mem_rdata_o,
    output logic               mem_ready_o
);

    // Only lines written over the bus are stored
    l2_pkg::line_data_t mem [l2_pkg::line_addr_t];

    integer     seed;
    integer     draw;
    logic       busy;
    logic [1:0] wait_cnt;

    initial begin
        seed        = SEED;
        mem_ready_o = 1'b0;
        mem_rdata_o = '0;
    end

    function automatic l2_pkg::line_data_t read_line(input l2_pkg::line_addr_t addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        // Address repeated over the line
        return {addr[15:0], {4{addr}}} ^ FILL_XOR;
    endfunction

    task automatic serve_command();
        mem_ready_o <= 1'b1;
        busy        <= 1'b0;
        if (mem_req_i.write) begin
            mem[mem_req_i.addr] = mem_req_i.wdata;
        end else begin
            mem_rdata_o <= read_line(mem_req_i.addr);
        end
    endtask

    always @(posedge clk) begin
        if (proc_reset) begin
            busy        <= 1'b0;
            wait_cnt    <= '0;
            mem_ready_o <= 1'b0;
            mem_rdata_o <= '0;
        end else if (mem_ready_o) begin
            // Command is dropped at this edge
            mem_ready_o <= 1'b0;
            mem_rdata_o <= '0;
        end else if (!busy) begin
            if (mem_req_i.read || mem_req_i.write) begin
                draw = $unsigned($random(seed)) % 4;
                if (draw == 0) begin
                    serve_command();
                end else begin
                    busy     <= 1'b1;
                    wait_cnt <= 2'(draw - 1);
                end
            end
        end else if (wait_cnt != 0) begin
            wait_cnt <= wait_cnt - 1'b1;
        end else begin
            serve_command();
        end
    end

endmodule

// ==== verification/tb_l2_cache.sv ====
`timescale 1ns/1ps

module tb_l2_cache;

    localparam int unsigned        SEED       = 32'hb7fc0594;
    localparam l2_pkg::line_data_t FILL_XOR   = 128'h3c96_a55a_0ff0_c33c_5aa5_9669_f00f_e11e;
    localparam l2_pkg::line_data_t WDATA_1    = 128'h1111_2222_3333_4444_5555_6666_7777_8888;
    localparam l2_pkg::line_data_t WDATA_2    = 128'hdead_beef_0123_4567_89ab_cdef_fedc_ba98;
    localparam l2_pkg::line_addr_t ADDR_A     = 28'h00012a2;
    localparam l2_pkg::line_addr_t ADDR_B     = 28'h00020c5;
    localparam l2_pkg::line_addr_t ADDR_C     = 28'h00030e9;
    // Same index as ADDR_C with another tag
    localparam l2_pkg::line_addr_t ADDR_D     = 28'h00031e9;
    localparam int                 N_DIRECTED = 12;
    localparam int                 N_RAND     = 40;
    // Slowest writeback and allocate plus a wait behind the other port
    localparam int                 WORST_CYC  = 40;

    logic               clk;
    logic               proc_reset;
    l2_pkg::l2_req_t    l1i_req;
    l2_pkg::l2_req_t    l1d_req;
    l2_pkg::line_data_t l1i_rdata;
    l2_pkg::line_data_t l1d_rdata;
    logic               l1i_ready;
    logic               l1d_ready;
    l2_pkg::mem_req_t   mem_req;
    l2_pkg::line_data_t mem_rdata;
    logic               mem_ready;

    // Last value written per line address
    l2_pkg::line_data_t shadow [l2_pkg::line_addr_t];

    integer             seed;
    int                 error_count;
    int                 mem_cmd_count;
    int                 mem_wr_count;
    l2_pkg::line_addr_t last_wr_addr;
    l2_pkg::line_data_t last_wr_data;

    l2_cache_top i_l2_cache_top (
        .clk         (clk),
        .proc_reset  (proc_reset),
        .l1i_req_i   (l1i_req),
        .l1i_rdata_o (l1i_rdata),
        .l1i_ready_o (l1i_ready),
        .l1d_req_i   (l1d_req),
        .l1d_rdata_o (l1d_rdata),
        .l1d_ready_o (l1d_ready),
        .mem_req_o   (mem_req),
        .mem_rdata_i (mem_rdata),
        .mem_ready_i (mem_ready)
    );

    l2_mem_model #(.FILL_XOR(FILL_XOR), .SEED(SEED)) i_l2_mem_model (
        .clk         (clk),
        .proc_reset  (proc_reset),
        .mem_req_i   (mem_req),
        .mem_rdata_o (mem_rdata),
        .mem_ready_o (mem_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic l2_pkg::line_data_t expected_line(input l2_pkg::line_addr_t addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return {addr[15:0], {4{addr}}} ^ FILL_XOR;
    endfunction

    task automatic stop_on_error(input string what);
        error_count++;
        $display("%s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input l2_pkg::line_data_t expected,
                                 input l2_pkg::line_data_t actual);
        assert (actual === expected) else begin
            stop_on_error($sformatf("FAIL %s expected %h got %h", name, expected, actual));
        end
    endtask

    task automatic check_port(input string name, input l2_pkg::l2_req_t req,
                              input logic ready, input l2_pkg::line_data_t rdata);
        if (ready) begin
            assert (req.read || req.write) else begin
                stop_on_error({name, " side pulsed ready with no request held"});
            end
            if (req.write) begin
                shadow[req.addr] = req.wdata;
            end else begin
                compare_value(name, expected_line(req.addr), rdata);
            end
        end
    endtask

    // Comparison and bus monitor at mid cycle
    always @(negedge clk) begin
        if (!proc_reset) begin
            check_port("l1i_rdata_o", l1i_req, l1i_ready, l1i_rdata);
            check_port("l1d_rdata_o", l1d_req, l1d_ready, l1d_rdata);
            assert (!(mem_req.read && mem_req.write)) else begin
                stop_on_error("Memory read and write were raised together");
            end
            if (mem_ready) begin
                mem_cmd_count++;
                if (mem_req.write) begin
                    mem_wr_count++;
                    last_wr_addr = mem_req.addr;
                    last_wr_data = mem_req.wdata;
                end
            end
        end
    end

    // Starts and returns a short delay after a rising edge
    task automatic line_access(input bit port, input bit wr, input l2_pkg::line_addr_t addr,
                               input l2_pkg::line_data_t wdata);
        l2_pkg::l2_req_t req;
        int              waited;
        req.read  = !wr;
        req.write = wr;
        req.addr  = addr;
        req.wdata = wdata;
        waited    = 0;
        if (port) begin
            l1d_req = req;
        end else begin
            l1i_req = req;
        end
        do begin
            @(negedge clk);
            waited++;
            assert (waited <= WORST_CYC) else begin
                stop_on_error("A request waited too long for its ready pulse");
            end
        end while (!(port ? l1d_ready : l1i_ready));
        @(posedge clk);
        #1;
        if (port) begin
            l1d_req = '0;
        end else begin
            l1i_req = '0;
        end
    endtask

    task automatic random_traffic(input bit port);
        l2_pkg::line_tag_t  tag;
        l2_pkg::set_index_t index;
        l2_pkg::line_data_t wdata;
        bit                 wr;
        for (int n = 0; n < N_RAND; n++) begin
            // Four tags over two indices
            tag   = l2_pkg::line_tag_t'($unsigned($random(seed)) % 4);
            index = (($random(seed) & 1) == 1) ? 5'd3 : 5'd17;
            wr    = (($random(seed) & 1) == 1);
            wdata = {$random(seed), $random(seed), $random(seed), $random(seed)};
            line_access(port, wr, {tag, index}, wr ? wdata : '0);
        end
    endtask

    initial begin
        repeat (3 + (N_DIRECTED + 2 * N_RAND) * WORST_CYC) @(posedge clk);
        stop_on_error("Timeout, a request never completed");
    end

    initial begin
        int cmd_before;
        int wr_before;
        seed          = SEED;
        error_count   = 0;
        mem_cmd_count = 0;
        mem_wr_count  = 0;
        proc_reset    = 1'b1;
        l1i_req       = '0;
        l1d_req       = '0;
        repeat (3) @(posedge clk);
        #1;
        proc_reset = 1'b0;

        @(negedge clk);
        assert (!l1i_ready && !l1d_ready && !mem_req.read && !mem_req.write) else begin
            stop_on_error("Ready or memory command active after reset");
        end
        compare_value("l1i_rdata_o", '0, l1i_rdata);
        compare_value("l1d_rdata_o", '0, l1d_rdata);
        @(posedge clk);
        #1;

        fork
            line_access(0, 0, ADDR_A, '0);
            line_access(1, 0, ADDR_B, '0);
        join
        cmd_before = mem_cmd_count;
        line_access(0, 0, ADDR_A, '0);
        line_access(1, 0, ADDR_A, '0);
        assert (mem_cmd_count == cmd_before) else begin
            stop_on_error("Read of a cached line went to memory");
        end

        // Write miss then write hit
        line_access(1, 1, ADDR_C, WDATA_1);
        line_access(0, 0, ADDR_C, '0);
        line_access(1, 0, ADDR_C, '0);
        line_access(1, 1, ADDR_C, WDATA_2);
        line_access(1, 0, ADDR_C, '0);
        line_access(0, 0, ADDR_C, '0);

        wr_before = mem_wr_count;
        line_access(1, 0, ADDR_D, '0);
        assert (mem_wr_count == wr_before + 1) else begin
            stop_on_error("Dirty victim was not written back");
        end
        compare_value("mem_req_o.addr", 128'(ADDR_C), 128'(last_wr_addr));
        compare_value("mem_req_o.wdata", WDATA_2, last_wr_data);
        line_access(0, 0, ADDR_C, '0);

        fork
            random_traffic(0);
            begin
                #1;
                random_traffic(1);
            end
        join

        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+include
hw/l2_pkg.sv
hw/l2_port_arbiter.sv
hw/l2_tag_data_array.sv
hw/l2_port_ctrl.sv
hw/l2_cache_top.sv
verification/l2_mem_model.sv
verification/tb_l2_cache.sv

// ==== Bender.yml ====
package:
  name: l2_cache

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/l2_pkg.sv
      - hw/l2_port_arbiter.sv
      - hw/l2_tag_data_array.sv
      - hw/l2_port_ctrl.sv
      - hw/l2_cache_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/l2_mem_model.sv
      - verification/tb_l2_cache.sv
